// ==== logic/pio_bus_decode.sv ====
module pio_bus_decode import pio_wmem_pkg::*; #(
	parameter int CLK_DIV_RATIO = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [PIO_ADDR_NBITS-1:0] pio_addr,
	input  logic [PIO_NBITS-1:0]      pio_din,
	input  logic                      pio_rd,
	input  logic                      pio_wr,
	input  logic                      mem_ack_a,
	input  logic [PIO_NBITS-1:0]      mem_rdata_a,
	input  logic                      mem_ack_b,
	input  logic [PIO_NBITS-1:0]      mem_rdata_b,
	output logic [PIO_NBITS-1:0]      pio_rdata,
	output logic                      pio_ack,
	output logic [PIO_ADDR_NBITS-1:0] reg_addr,
	output logic [PIO_NBITS-1:0]      reg_din,
	output logic                      reg_rd,
	output logic                      reg_wr,
	output logic                      reg_ms_a,
	output logic                      reg_ms_b,
	output logic                      clk_div
);

	localparam int CNT_NBITS = $clog2(CLK_DIV_RATIO);
	localparam logic [CNT_NBITS-1:0] CNT_LAST = CNT_NBITS'(CLK_DIV_RATIO - 1);

	logic [CNT_NBITS-1:0]    div_cnt;
	logic [REGION_NBITS-1:0] region;
	logic [REGION_NBITS-1:0] region_q;
	logic                    unmap_req;
	logic                    unmap_pend;
	logic                    unmap_ack;

	// the bus itself reaches both memories untouched.
	assign reg_addr = pio_addr;
	assign reg_din  = pio_din;
	assign reg_rd   = pio_rd;
	assign reg_wr   = pio_wr;

	// the select levels follow the region field of the current address.
	assign region   = pio_addr[PIO_ADDR_NBITS-1:REGION_LSB];
	assign reg_ms_a = (region == REGION_WMEM_A);
	assign reg_ms_b = (region == REGION_WMEM_B);
	assign unmap_req = (pio_rd | pio_wr) & ~reg_ms_a & ~reg_ms_b;

	// free-running divider, one strobe every CLK_DIV_RATIO cycles.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			div_cnt <= '0;
			clk_div <= 1'b0;
		end else begin
			clk_div <= (div_cnt == CNT_LAST);
			if (div_cnt == CNT_LAST) begin
				div_cnt <= '0;
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// the region of the last access steers the return path until the next one.
	// Unmapped accesses are acked here on the same divider pacing as a memory.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			region_q   <= REGION_WMEM_A;
			unmap_pend <= 1'b0;
			unmap_ack  <= 1'b0;
		end else begin
			if (pio_rd || pio_wr) begin
				region_q <= region;
			end
			if (unmap_req) begin
				unmap_pend <= 1'b1;
			end else if (clk_div) begin
				unmap_pend <= 1'b0;
			end
			if (clk_div) begin
				unmap_ack <= unmap_pend;
			end
		end
	end

	always_comb begin
		case (region_q)
			REGION_WMEM_A: begin
				pio_ack   = mem_ack_a;
				pio_rdata = mem_rdata_a;
			end
			REGION_WMEM_B: begin
				pio_ack   = mem_ack_b;
				pio_rdata = mem_rdata_b;
			end
			default: begin
				pio_ack   = unmap_ack;
				pio_rdata = '0;
			end
		endcase
	end

endmodule

// ==== logic/pio_wmem_bram.sv ====
module pio_wmem_bram import pio_wmem_pkg::*; #(
	parameter int WIDTH = 50,
	parameter int DEPTH_NBITS = 10
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      clk_div,
	input  logic [PIO_ADDR_NBITS-1:0] reg_addr,
	input  logic [PIO_NBITS-1:0]      reg_din,
	input  logic                      reg_rd,
	input  logic                      reg_wr,
	input  logic                      reg_ms,
	input  logic                      app_mem_rd,
	input  logic [DEPTH_NBITS-1:0]    app_mem_raddr,
	output logic                      mem_ack,
	output logic [PIO_NBITS-1:0]      mem_rdata,
	output logic                      app_mem_ack,
	output logic [WIDTH-1:0]          app_mem_rdata
);

	// number of entry bits that sit above the low dword.
	localparam int HI_NBITS = WIDTH - PIO_NBITS;

	// bit 2 picks the dword of an entry and the bits above it pick the entry.
	logic                   dw_hi;
	logic [DEPTH_NBITS-1:0] reg_idx;
	logic                   pio_wr_lo;
	logic                   pio_wr_hi;
	logic                   pio_rd_lo;
	logic                   pio_rd_hi;

	// application read pipeline and the address it puts on the RAM.
	logic                   app_rd_d1;
	logic                   app_rd_d2;
	logic [DEPTH_NBITS-1:0] app_raddr_d1;

	// a low read that lost the RAM port waits here with its entry index.
	logic                   rd_save;
	logic [DEPTH_NBITS-1:0] rd_save_idx;
	logic                   ram_rd_lo;
	logic                   ram_rd_lo_d1;

	// holding registers that turn two dword accesses into one wide access.
	logic [PIO_NBITS-1:0]   wdata_lo;
	logic [HI_NBITS-1:0]    rdata_hi_q;
	logic [PIO_NBITS-1:0]   rdata_hi_ext;
	logic                   ack_pend;

	logic [DEPTH_NBITS-1:0] ram_raddr;
	logic [WIDTH-1:0]       ram_wdata;
	logic [WIDTH-1:0]       ram_rdata;

	assign dw_hi   = reg_addr[2];
	assign reg_idx = reg_addr[3 +: DEPTH_NBITS];

	assign pio_wr_lo = reg_ms & reg_wr & ~dw_hi;
	assign pio_wr_hi = reg_ms & reg_wr & dw_hi;
	assign pio_rd_lo = reg_ms & reg_rd & ~dw_hi;
	assign pio_rd_hi = reg_ms & reg_rd & dw_hi;

	// the application owns the read port in the cycle after its strobe.
	// A new or saved PIO low read only goes to the RAM when the port is free.
	assign ram_rd_lo = ~app_rd_d1 & (pio_rd_lo | rd_save);

	always_comb begin
		if (app_rd_d1) begin
			ram_raddr = app_raddr_d1;
		end else if (rd_save) begin
			ram_raddr = rd_save_idx;
		end else begin
			ram_raddr = reg_idx;
		end
	end

	// the high write supplies the upper bits and commits the whole entry.
	assign ram_wdata = {reg_din[HI_NBITS-1:0], wdata_lo};

	// the saved upper bits are returned zero-extended to a full dword.
	always_comb begin
		rdata_hi_ext = '0;
		rdata_hi_ext[HI_NBITS-1:0] = rdata_hi_q;
	end

	ram_1r1w_bram #(
		.WIDTH(WIDTH),
		.DEPTH_NBITS(DEPTH_NBITS)
	) u_ram (
		.clk(clk),
		.wr(pio_wr_hi),
		.waddr(reg_idx),
		.raddr(ram_raddr),
		.din(ram_wdata),
		.dout(ram_rdata)
	);

	// payload registers.
	// The upper bits of a low read stay put until the next low read returns.
	always_ff @(posedge clk) begin
		app_raddr_d1  <= app_mem_raddr;
		app_mem_rdata <= ram_rdata;
		if (pio_wr_lo) begin
			wdata_lo <= reg_din;
		end
		if (pio_rd_lo) begin
			rd_save_idx <= reg_idx;
		end
		if (ram_rd_lo_d1) begin
			mem_rdata  <= ram_rdata[PIO_NBITS-1:0];
			rdata_hi_q <= ram_rdata[WIDTH-1:PIO_NBITS];
		end else if (pio_rd_hi) begin
			mem_rdata <= rdata_hi_ext;
		end
	end

	// control state.
	// The application path is a fixed pipeline: strobe, RAM address, RAM data.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			app_rd_d1    <= 1'b0;
			app_rd_d2    <= 1'b0;
			app_mem_ack  <= 1'b0;
			rd_save      <= 1'b0;
			ram_rd_lo_d1 <= 1'b0;
			ack_pend     <= 1'b0;
			mem_ack      <= 1'b0;
		end else begin
			app_rd_d1    <= app_mem_rd;
			app_rd_d2    <= app_rd_d1;
			app_mem_ack  <= app_rd_d2;
			ram_rd_lo_d1 <= ram_rd_lo;
			// a blocked low read is kept until it reaches the RAM.
			if (pio_rd_lo && app_rd_d1) begin
				rd_save <= 1'b1;
			end else if (ram_rd_lo) begin
				rd_save <= 1'b0;
			end
			// a new event wins over the strobe that would clear the flag.
			if (pio_wr_lo || pio_wr_hi || pio_rd_hi || ram_rd_lo_d1) begin
				ack_pend <= 1'b1;
			end else if (clk_div) begin
				ack_pend <= 1'b0;
			end
			// the ack follows the pending flag one strobe at a time.
			if (clk_div) begin
				mem_ack <= ack_pend;
			end
		end
	end

endmodule

// ==== logic/pio_wmem_pkg.sv ====
package pio_wmem_pkg;

	// the programmed-I/O bus moves one 32-bit dword per access.
	localparam int PIO_NBITS = 32;

	// byte address width of the PIO bus.
	// Bits 1..0 are never looked at, since every access is a full dword.
	localparam int PIO_ADDR_NBITS = 16;

	// the top address bits form the region field that picks a target block.
	// Bits below the region field are left to the target for its own decode.
	localparam int REGION_LSB = 13;

	// width of the region field, bits 15..13 of the byte address.
	localparam int REGION_NBITS = PIO_ADDR_NBITS - REGION_LSB;

	// region code of wide memory A.
	localparam logic [REGION_NBITS-1:0] REGION_WMEM_A = 3'd0;

	// region code of wide memory B.
	// Any region code that is neither A nor B is unmapped.
	// The decoder then answers the access by itself with zero data.
	localparam logic [REGION_NBITS-1:0] REGION_WMEM_B = 3'd1;

endpackage

// ==== logic/ram_1r1w_bram.sv ====
module ram_1r1w_bram #(
	parameter int WIDTH = 50,
	parameter int DEPTH_NBITS = 10
) (
	input  logic                   clk,
	input  logic                   wr,
	input  logic [DEPTH_NBITS-1:0] waddr,
	input  logic [DEPTH_NBITS-1:0] raddr,
	input  logic [WIDTH-1:0]       din,
	output logic [WIDTH-1:0]       dout
);

	// the storage array maps onto a simple dual-port block RAM.
	// One port only writes and the other port only reads.
	logic [WIDTH-1:0] mem [2**DEPTH_NBITS];

	// the write port stores din at waddr whenever wr is high.
	always_ff @(posedge clk) begin
		if (wr) begin
			mem[waddr] <= din;
		end
	end

	// the read port is registered, so data appears one cycle after raddr.
	// A read of the address being written in the same cycle returns the
	// word as it was before the write.
	always_ff @(posedge clk) begin
		dout <= mem[raddr];
	end

endmodule

// ==== logic/wmem_subsys_top.sv ====
module wmem_subsys_top import pio_wmem_pkg::*; #(
	parameter int WIDTH_A = 50,
	parameter int DEPTH_NBITS_A = 10,
	parameter int WIDTH_B = 40,
	parameter int DEPTH_NBITS_B = 8,
	parameter int CLK_DIV_RATIO = 4
) (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic [PIO_ADDR_NBITS-1:0] pio_addr,
	input  logic [PIO_NBITS-1:0]      pio_din,
	input  logic                      pio_rd,
	input  logic                      pio_wr,
	input  logic                      app_a_rd,
	input  logic [DEPTH_NBITS_A-1:0]  app_a_raddr,
	input  logic                      app_b_rd,
	input  logic [DEPTH_NBITS_B-1:0]  app_b_raddr,
	output logic [PIO_NBITS-1:0]      pio_rdata,
	output logic                      pio_ack,
	output logic                      app_a_ack,
	output logic [WIDTH_A-1:0]        app_a_rdata,
	output logic                      app_b_ack,
	output logic [WIDTH_B-1:0]        app_b_rdata
);

	// decoded bus shared by both memories.
	logic [PIO_ADDR_NBITS-1:0] reg_addr;
	logic [PIO_NBITS-1:0]      reg_din;
	logic                      reg_rd;
	logic                      reg_wr;
	logic                      reg_ms_a;
	logic                      reg_ms_b;
	logic                      clk_div;

	// per-memory return path into the decoder mux.
	logic                      mem_ack_a;
	logic [PIO_NBITS-1:0]      mem_rdata_a;
	logic                      mem_ack_b;
	logic [PIO_NBITS-1:0]      mem_rdata_b;

	pio_bus_decode #(
		.CLK_DIV_RATIO(CLK_DIV_RATIO)
	) u_decode (
		.clk(clk),
		.rst_n(rst_n),
		.pio_addr(pio_addr),
		.pio_din(pio_din),
		.pio_rd(pio_rd),
		.pio_wr(pio_wr),
		.mem_ack_a(mem_ack_a),
		.mem_rdata_a(mem_rdata_a),
		.mem_ack_b(mem_ack_b),
		.mem_rdata_b(mem_rdata_b),
		.pio_rdata(pio_rdata),
		.pio_ack(pio_ack),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr),
		.reg_ms_a(reg_ms_a),
		.reg_ms_b(reg_ms_b),
		.clk_div(clk_div)
	);

	// memory A, the wider and deeper table.
	pio_wmem_bram #(
		.WIDTH(WIDTH_A),
		.DEPTH_NBITS(DEPTH_NBITS_A)
	) u_wmem_a (
		.clk(clk),
		.rst_n(rst_n),
		.clk_div(clk_div),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr),
		.reg_ms(reg_ms_a),
		.app_mem_rd(app_a_rd),
		.app_mem_raddr(app_a_raddr),
		.mem_ack(mem_ack_a),
		.mem_rdata(mem_rdata_a),
		.app_mem_ack(app_a_ack),
		.app_mem_rdata(app_a_rdata)
	);

	// memory B, narrower entries and fewer of them.
	pio_wmem_bram #(
		.WIDTH(WIDTH_B),
		.DEPTH_NBITS(DEPTH_NBITS_B)
	) u_wmem_b (
		.clk(clk),
		.rst_n(rst_n),
		.clk_div(clk_div),
		.reg_addr(reg_addr),
		.reg_din(reg_din),
		.reg_rd(reg_rd),
		.reg_wr(reg_wr),
		.reg_ms(reg_ms_b),
		.app_mem_rd(app_b_rd),
		.app_mem_raddr(app_b_raddr),
		.mem_ack(mem_ack_b),
		.mem_rdata(mem_rdata_b),
		.app_mem_ack(app_b_ack),
		.app_mem_rdata(app_b_rdata)
	);

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root.
# The run counts as passed only if the pass line shows up in the output.
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module wmem_subsys_tb -f wmem_subsys.f &&
./obj_dir/Vwmem_subsys_tb | grep -q "Simulation passed" &&
echo "run_sim: passed" ||
{ echo "run_sim: failed"; exit 1; }

// ==== verif/wmem_subsys_tb.sv ====
module wmem_subsys_tb import pio_wmem_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WIDTH_A = 50;
	localparam int DEPTH_A = 10;
	localparam int WIDTH_B = 40;
	localparam int DEPTH_B = 8;
	localparam int APP_LATENCY = 3;
	localparam int ACK_TIMEOUT = 64;
	localparam int NUM_RANDOM = 40;

	logic                      clk;
	logic                      rst_n;
	logic [PIO_ADDR_NBITS-1:0] pio_addr;
	logic [PIO_NBITS-1:0]      pio_din;
	logic                      pio_rd;
	logic                      pio_wr;
	logic                      app_a_rd;
	logic [DEPTH_A-1:0]        app_a_raddr;
	logic                      app_b_rd;
	logic [DEPTH_B-1:0]        app_b_raddr;
	logic [PIO_NBITS-1:0]      pio_rdata;
	logic                      pio_ack;
	logic                      app_a_ack;
	logic [WIDTH_A-1:0]        app_a_rdata;
	logic                      app_b_ack;
	logic [WIDTH_B-1:0]        app_b_rdata;

	// reference copies of both memories, updated by every PIO entry write.
	logic [WIDTH_A-1:0] model_a [2**DEPTH_A];
	logic [WIDTH_B-1:0] model_b [2**DEPTH_B];

	wmem_subsys_top dut (
		.clk(clk),
		.rst_n(rst_n),
		.pio_addr(pio_addr),
		.pio_din(pio_din),
		.pio_rd(pio_rd),
		.pio_wr(pio_wr),
		.app_a_rd(app_a_rd),
		.app_a_raddr(app_a_raddr),
		.app_b_rd(app_b_rd),
		.app_b_raddr(app_b_raddr),
		.pio_rdata(pio_rdata),
		.pio_ack(pio_ack),
		.app_a_ack(app_a_ack),
		.app_a_rdata(app_a_rdata),
		.app_b_ack(app_b_ack),
		.app_b_rdata(app_b_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("ERROR: %s", why);
		$display("Simulation failed");
		$fatal(1, "run stopped on error");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
			input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp);
			$display("Simulation failed");
			$fatal(1, "value mismatch");
		end
	endtask

	function automatic logic [REGION_NBITS-1:0] region_of(input bit mem_b);
		return mem_b ? REGION_WMEM_B : REGION_WMEM_A;
	endfunction

	// byte address of one dword of an entry.
	// The region sits on top, the entry index starts at bit 3 and bit 2 picks the dword.
	function automatic logic [PIO_ADDR_NBITS-1:0] entry_addr(
			input logic [REGION_NBITS-1:0] region, input int idx, input bit hi);
		return {region, REGION_LSB'(idx * 8 + (hi ? 4 : 0))};
	endfunction

	// the expected entry comes from the model, zero-extended to 64 bits.
	function automatic logic [63:0] expected_entry(input bit mem_b, input int idx);
		if (mem_b) begin
			return 64'(model_b[DEPTH_B'(idx)]);
		end
		return 64'(model_a[DEPTH_A'(idx)]);
	endfunction

	// the ack is a level, so wait for it to rise and then to fall again.
	task automatic wait_pio_ack(output logic [PIO_NBITS-1:0] data);
		int n;
		n = 0;
		while (pio_ack !== 1'b1) begin
			@(negedge clk);
			n++;
			if (n > ACK_TIMEOUT) abort_run("pio_ack did not rise in time");
		end
		data = pio_rdata;
		n = 0;
		while (pio_ack !== 1'b0) begin
			@(negedge clk);
			n++;
			if (n > ACK_TIMEOUT) abort_run("pio_ack did not fall in time");
		end
	endtask

	task automatic pio_write(input logic [PIO_ADDR_NBITS-1:0] addr,
			input logic [PIO_NBITS-1:0] data);
		logic [PIO_NBITS-1:0] unused;
		@(negedge clk);
		pio_addr = addr;
		pio_din = data;
		pio_wr = 1'b1;
		@(negedge clk);
		pio_wr = 1'b0;
		wait_pio_ack(unused);
	endtask

	task automatic pio_read(input logic [PIO_ADDR_NBITS-1:0] addr,
			output logic [PIO_NBITS-1:0] data);
		@(negedge clk);
		pio_addr = addr;
		pio_rd = 1'b1;
		@(negedge clk);
		pio_rd = 1'b0;
		wait_pio_ack(data);
	endtask

	// an entry is written as its low dword first, then the high dword commits it.
	task automatic write_entry(input bit mem_b, input int idx, input logic [63:0] value);
		pio_write(entry_addr(region_of(mem_b), idx, 1'b0), value[31:0]);
		pio_write(entry_addr(region_of(mem_b), idx, 1'b1), value[63:32]);
		if (mem_b) begin
			model_b[DEPTH_B'(idx)] = value[WIDTH_B-1:0];
		end else begin
			model_a[DEPTH_A'(idx)] = value[WIDTH_A-1:0];
		end
	endtask

	task automatic read_entry_pio(input bit mem_b, input int idx);
		logic [PIO_NBITS-1:0] lo;
		logic [PIO_NBITS-1:0] hi;
		logic [63:0]          exp;
		exp = expected_entry(mem_b, idx);
		pio_read(entry_addr(region_of(mem_b), idx, 1'b0), lo);
		check_value("pio_rdata low", 64'(lo), {32'h0, exp[31:0]});
		pio_read(entry_addr(region_of(mem_b), idx, 1'b1), hi);
		check_value("pio_rdata high", 64'(hi), exp >> 32);
	endtask

	// one application read, counting negedges from the strobe to the ack.
	task automatic app_read(input bit mem_b, input int idx, output logic [63:0] data,
			output int cycles);
		logic got_ack;
		@(negedge clk);
		if (mem_b) begin
			app_b_rd = 1'b1;
			app_b_raddr = DEPTH_B'(idx);
		end else begin
			app_a_rd = 1'b1;
			app_a_raddr = DEPTH_A'(idx);
		end
		@(negedge clk);
		app_a_rd = 1'b0;
		app_b_rd = 1'b0;
		cycles = 1;
		got_ack = mem_b ? app_b_ack : app_a_ack;
		while (!got_ack) begin
			@(negedge clk);
			cycles++;
			if (cycles > ACK_TIMEOUT) abort_run("application read ack did not arrive");
			got_ack = mem_b ? app_b_ack : app_a_ack;
		end
		if (mem_b) begin
			data = 64'(app_b_rdata);
		end else begin
			data = 64'(app_a_rdata);
		end
	endtask

	task automatic check_app(input bit mem_b, input int idx);
		logic [63:0] data;
		int          cycles;
		app_read(mem_b, idx, data, cycles);
		check_value("app read latency", 64'(cycles), 64'(APP_LATENCY));
		check_value(mem_b ? "app_b_rdata" : "app_a_rdata", data, expected_entry(mem_b, idx));
	endtask

	// reads on consecutive cycles; the fixed latency says which negedge carries which entry.
	task automatic app_burst_a(input int idxs[$]);
		for (int k = 0; k < idxs.size() + APP_LATENCY; k++) begin
			@(negedge clk);
			check_value("app_a_ack", 64'(app_a_ack), 64'(k >= APP_LATENCY));
			if (k >= APP_LATENCY) begin
				check_value("app_a_rdata", 64'(app_a_rdata),
					expected_entry(1'b0, idxs[k-APP_LATENCY]));
			end
			if (k < idxs.size()) begin
				app_a_rd = 1'b1;
				app_a_raddr = DEPTH_A'(idxs[k]);
			end else begin
				app_a_rd = 1'b0;
			end
		end
	endtask

	task automatic round_trip_a();
		write_entry(1'b0, 5, 64'h0002_abcd_1234_5678);
		read_entry_pio(1'b0, 5);
	endtask

	// bits above 40 in the high dword are dropped by memory B.
	task automatic top_entry_b();
		write_entry(1'b0, 255, 64'h0001_1111_2222_3333);
		write_entry(1'b1, 255, 64'hffff_ff9a_5566_7788);
		read_entry_pio(1'b1, 255);
		read_entry_pio(1'b0, 255);
	endtask

	task automatic app_port_reads();
		check_app(1'b0, 5);
		check_app(1'b1, 255);
		check_app(1'b0, 255);
		write_entry(1'b0, 10, 64'h0003_0000_0a0a_0a0a);
		write_entry(1'b0, 11, 64'h0000_1234_b1b1_b1b1);
		write_entry(1'b0, 12, 64'h0001_ffff_c2c2_c2c2);
		app_burst_a('{10, 11, 12, 5});
	endtask

	// the PIO low read lands while the application read still holds the RAM port.
	task automatic collide_app_pio();
		logic [PIO_NBITS-1:0] lo;
		logic [PIO_NBITS-1:0] hi;
		write_entry(1'b0, 20, 64'h0002_2020_dead_beef);
		write_entry(1'b0, 21, 64'h0001_2121_cafe_f00d);
		@(negedge clk);
		app_a_rd = 1'b1;
		app_a_raddr = DEPTH_A'(20);
		@(negedge clk);
		app_a_rd = 1'b0;
		pio_addr = entry_addr(REGION_WMEM_A, 21, 1'b0);
		pio_rd = 1'b1;
		@(negedge clk);
		pio_rd = 1'b0;
		@(negedge clk);
		check_value("app_a_ack", 64'(app_a_ack), 64'd1);
		check_value("app_a_rdata", 64'(app_a_rdata), expected_entry(1'b0, 20));
		wait_pio_ack(lo);
		check_value("pio_rdata low", 64'(lo), expected_entry(1'b0, 21) & 64'hffff_ffff);
		pio_read(entry_addr(REGION_WMEM_A, 21, 1'b1), hi);
		check_value("pio_rdata high", 64'(hi), expected_entry(1'b0, 21) >> 32);
	endtask

	// region 5 maps to nothing, and its index bits alias entry 255 of both memories.
	task automatic unmapped_region();
		logic [PIO_NBITS-1:0] data;
		pio_read(entry_addr(3'd5, 255, 1'b0), data);
		check_value("pio_rdata unmapped", 64'(data), 64'd0);
		pio_write(entry_addr(3'd5, 255, 1'b0), 32'h5555_aaaa);
		pio_write(entry_addr(3'd5, 255, 1'b1), 32'haaaa_5555);
		read_entry_pio(1'b0, 255);
		read_entry_pio(1'b1, 255);
	endtask

	task automatic random_fill();
		int idx_a[$];
		int idx_b[$];
		int idx;
		for (int i = 0; i < NUM_RANDOM; i++) begin
			idx = int'($urandom % (2**DEPTH_A));
			write_entry(1'b0, idx, {$urandom, $urandom});
			idx_a.push_back(idx);
			idx = int'($urandom % (2**DEPTH_B));
			write_entry(1'b1, idx, {$urandom, $urandom});
			idx_b.push_back(idx);
		end
		foreach (idx_a[i]) check_app(1'b0, idx_a[i]);
		foreach (idx_b[i]) check_app(1'b1, idx_b[i]);
	endtask

	initial begin
		void'($urandom(32'ha702_8504));
		rst_n = 1'b0;
		pio_addr = '0;
		pio_din = '0;
		pio_rd = 1'b0;
		pio_wr = 1'b0;
		app_a_rd = 1'b0;
		app_a_raddr = '0;
		app_b_rd = 1'b0;
		app_b_raddr = '0;
		repeat (2) @(negedge clk);
		rst_n = 1'b1;
		round_trip_a();
		top_entry_b();
		app_port_reads();
		collide_app_pio();
		unmapped_region();
		random_fill();
		$display("Simulation passed");
		$finish;
	end

endmodule

// ==== wmem_subsys.f ====
logic/pio_wmem_pkg.sv
logic/ram_1r1w_bram.sv
logic/pio_wmem_bram.sv
logic/pio_bus_decode.sv
logic/wmem_subsys_top.sv
verif/wmem_subsys_tb.sv
